//--- include/filter_params.svh
// ==============================
// Banked counting filter sizes
// Bank count, bucket geometry and remove queue limits
// ==============================

`ifndef FILTER_PARAMS_SVH
`define FILTER_PARAMS_SVH

// Log2 of the bank count, so the number of banks is always a power of two
`define FILTER_N_BANKS_RADIX 2

// Total buckets over all banks
`define FILTER_N_BUCKETS 64

// Width of one bucket counter
`define FILTER_BITS_PER_BUCKET 4

// Remove queue depth and the free-entry level that raises almost-full
`define FILTER_REMOVE_DEPTH 8
`define FILTER_REMOVE_THRESHOLD 2

`endif

//--- logic/filter_pkg.sv
// ==============================
// Banked counting filter types
// Index, value and per-bank command encodings
// ==============================

`include "filter_params.svh"

package filter_pkg;

    // ==============================
    // Scalar types
    // ==============================

    // Global bucket index as seen by clients
    typedef logic [$clog2(`FILTER_N_BUCKETS)-1:0] bucket_idx_t;

    // Bank number, taken from the low bits of a bucket index
    typedef logic [`FILTER_N_BANKS_RADIX-1:0] bank_idx_t;

    // Bucket index within one bank
    typedef logic [$clog2(`FILTER_N_BUCKETS)-`FILTER_N_BANKS_RADIX-1:0] bank_bucket_t;

    // Counter value held in each bucket
    typedef logic [`FILTER_BITS_PER_BUCKET-1:0] bucket_value_t;

    // ==============================
    // Index decoding
    // ==============================

    // Split view of a bucket index with the bank in the low bits
    typedef struct packed {
        bank_bucket_t bucket;
        bank_idx_t    bank;
    } bucket_split_t;

    // The same index word read either whole or as bank plus bank bucket
    typedef union packed {
        bucket_idx_t   idx;
        bucket_split_t split;
    } bucket_word_u;

    // ==============================
    // Bank commands
    // ==============================

    // One bank's update slot for the cycle
    // A clear is_insert means the update is a removal
    typedef struct packed {
        logic         en;
        logic         is_insert;
        bank_bucket_t bucket;
    } bank_update_t;

    // Test lookups broadcast to every bank
    typedef struct packed {
        bank_bucket_t value_bucket;
        bank_bucket_t zero_bucket;
    } bank_test_t;

endpackage

//--- logic/remove_queue.sv
// ==============================
// Remove queue
// Circular FIFO of removal requests waiting for a bank update slot
// ==============================

`timescale 1ns/1ps
`include "filter_params.svh"

module remove_queue
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enq_en,
    input  filter_pkg::bucket_idx_t enq_data,
    input  logic                    deq,
    output filter_pkg::bucket_idx_t head,
    output logic                    valid,
    output logic                    not_full,
    output logic                    almost_full
);

    localparam int DEPTH = `FILTER_REMOVE_DEPTH;
    localparam int THRESHOLD = `FILTER_REMOVE_THRESHOLD;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    filter_pkg::bucket_idx_t entries [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    // Occupancy, wide enough to hold DEPTH itself
    logic [CNT_W-1:0] count;

    // Pointer advance with explicit wrap so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            entries[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (deq)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Count only moves when exactly one side is active
            case ({enq_en, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head is read straight from storage, so a new entry shows the cycle after its write
    assign head = entries[rd_ptr];
    assign valid = (count != '0);
    assign not_full = (count != CNT_W'(DEPTH));
    assign almost_full = ((CNT_W'(DEPTH) - count) <= CNT_W'(THRESHOLD));

    // The client must watch not_full before pushing another removal
    assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full)
        else $error("remove_queue: enqueue while full");

    // The router may only grant the head when the queue holds one
    assert property (@(posedge clk) disable iff (reset) deq |-> valid)
        else $error("remove_queue: dequeue while empty");

endmodule

//--- logic/bank_router.sv
// ==============================
// Bank router
// Splits requests by bank and grants the remove head a free update slot
// ==============================

`timescale 1ns/1ps
`include "filter_params.svh"

module bank_router
#(
    parameter int N_BANKS = 1 << `FILTER_N_BANKS_RADIX
)
(
    input  logic                     insert_en,
    input  filter_pkg::bucket_idx_t  insert,
    input  filter_pkg::bucket_idx_t  head,
    input  filter_pkg::bucket_idx_t  test_value_req,
    input  filter_pkg::bucket_idx_t  test_is_zero_req,
    input  logic                     head_valid,
    output logic                     deq,
    output filter_pkg::bank_update_t upd [N_BANKS],
    output filter_pkg::bank_test_t   tests
);

    // Each incoming index viewed through the bank split
    filter_pkg::bucket_word_u insert_w;
    filter_pkg::bucket_word_u head_w;
    filter_pkg::bucket_word_u value_w;
    filter_pkg::bucket_word_u zero_w;

    always_comb
    begin
        insert_w.idx = insert;
        head_w.idx = head;
        value_w.idx = test_value_req;
        zero_w.idx = test_is_zero_req;
    end

    // ==============================
    // Update slot arbitration
    // ==============================

    always_comb
    begin
        // Insertion owns its bank's slot, so the head waits only on a bank clash
        deq = head_valid &&
              !(insert_en && (insert_w.split.bank == head_w.split.bank));

        for (int b = 0; b < N_BANKS; b++)
        begin
            upd[b] = '0;
            if (insert_en && (insert_w.split.bank == filter_pkg::bank_idx_t'(b)))
            begin
                upd[b].en = 1'b1;
                upd[b].is_insert = 1'b1;
                upd[b].bucket = insert_w.split.bucket;
            end
            else if (deq && (head_w.split.bank == filter_pkg::bank_idx_t'(b)))
            begin
                upd[b].en = 1'b1;
                upd[b].is_insert = 1'b0;
                upd[b].bucket = head_w.split.bucket;
            end
        end
    end

    // ==============================
    // Test broadcast
    // ==============================

    // Every bank looks up the same bank bucket and the selector picks the right one later
    always_comb
    begin
        tests.value_bucket = value_w.split.bucket;
        tests.zero_bucket = zero_w.split.bucket;
    end

endmodule

//--- logic/counter_bank.sv
// ==============================
// Counter bank
// Read-modify-write counter memory with bypassed test ports
// ==============================

`timescale 1ns/1ps

module counter_bank
(
    input  logic                      clk,
    input  logic                      reset,
    input  filter_pkg::bank_update_t  upd,
    input  filter_pkg::bank_test_t    tests,
    output filter_pkg::bucket_value_t value,
    output logic                      is_zero
);

    localparam int N_ENTRIES = 2 ** $bits(filter_pkg::bank_bucket_t);
    // Copy 0 serves updates, copy 1 the value test and copy 2 the zero test
    localparam int N_COPIES = 3;
    localparam int N_TEST_PORTS = 2;

    // A test port's pending bypass
    typedef struct packed {
        logic                      hit;
        filter_pkg::bucket_value_t val;
    } bypass_t;

    // Write port shared by all copies
    logic                      wr_en;
    filter_pkg::bank_bucket_t  wr_idx;
    filter_pkg::bucket_value_t wr_val;

    filter_pkg::bank_bucket_t  rd_idx [N_COPIES];
    filter_pkg::bucket_value_t rd_val [N_COPIES];

    // ==============================
    // Counter memories
    // ==============================

    for (genvar c = 0; c < N_COPIES; c++)
    begin : copy
        filter_pkg::bucket_value_t mem [N_ENTRIES];
        filter_pkg::bucket_value_t rd_data;

        // Counters start at zero and the read returns the value before a same-cycle write
        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                for (int i = 0; i < N_ENTRIES; i++)
                begin
                    mem[i] <= '0;
                end
            end
            else if (wr_en)
            begin
                mem[wr_idx] <= wr_val;
            end
            rd_data <= mem[rd_idx[c]];
        end

        assign rd_val[c] = rd_data;
    end

    assign rd_idx[0] = upd.bucket;
    assign rd_idx[1] = tests.value_bucket;
    assign rd_idx[2] = tests.zero_bucket;

    // ==============================
    // Update pipeline
    // ==============================

    // Stage 1 holds the read in flight, stage 2 writes, and stage 3 is the write just done
    filter_pkg::bank_update_t upd_q [1:3];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            upd_q[1] <= '0;
            upd_q[2] <= '0;
            upd_q[3] <= '0;
        end
        else
        begin
            upd_q[1] <= upd;
            upd_q[2] <= upd_q[1];
            upd_q[3] <= upd_q[2];
        end
    end

    // Contribution of one update to the running delta
    function automatic logic signed [2:0] step(input logic hit, input logic is_insert);
        if (!hit)
        begin
            return 3'sd0;
        end
        return is_insert ? 3'sd1 : -3'sd1;
    endfunction

    logic signed [2:0]         delta;
    filter_pkg::bucket_value_t new_val;

    // The read for stage 1 misses the writes of stages 2 and 3, so those are folded in here
    always_comb
    begin
        delta = step(1'b1, upd_q[1].is_insert)
              + step(upd_q[2].en && (upd_q[2].bucket == upd_q[1].bucket), upd_q[2].is_insert)
              + step(upd_q[3].en && (upd_q[3].bucket == upd_q[1].bucket), upd_q[3].is_insert);
        new_val = rd_val[0] + filter_pkg::bucket_value_t'(delta);
    end

    always_ff @(posedge clk)
    begin
        wr_val <= new_val;
    end

    assign wr_en = upd_q[2].en;
    assign wr_idx = upd_q[2].bucket;

    // ==============================
    // Test read ports
    // ==============================

    filter_pkg::bucket_value_t test_result [N_TEST_PORTS];

    for (genvar p = 0; p < N_TEST_PORTS; p++)
    begin : port
        filter_pkg::bank_bucket_t  idx [0:1];
        bypass_t                   byp [0:2];
        filter_pkg::bucket_value_t mem_q;

        assign idx[0] = rd_idx[p + 1];
        // A write in the request cycle lands too late for the memory read
        assign byp[0] = '{hit: wr_en && (idx[0] == wr_idx), val: wr_val};

        always_ff @(posedge clk)
        begin
            idx[1] <= idx[0];
            byp[1] <= byp[0];
            // A newer write to the same bucket replaces any older bypass
            if (wr_en && (idx[1] == wr_idx))
            begin
                byp[2] <= '{hit: 1'b1, val: wr_val};
            end
            else
            begin
                byp[2] <= byp[1];
            end
            mem_q <= rd_val[p + 1];
        end

        assign test_result[p] = byp[2].hit ? byp[2].val : mem_q;
    end

    assign value = test_result[0];
    assign is_zero = (test_result[1] == '0);

    // An insert that wraps to zero means the counter was already full
    assert property (@(posedge clk) disable iff (reset)
        (wr_en && upd_q[2].is_insert) |-> (wr_val != '0))
        else $error("counter_bank: insert overflowed bucket %0d", wr_idx);

    // A removal that wraps to all ones means the counter was already zero
    assert property (@(posedge clk) disable iff (reset)
        (wr_en && !upd_q[2].is_insert) |-> (wr_val != '1))
        else $error("counter_bank: remove underflowed bucket %0d", wr_idx);

endmodule

//--- logic/result_select.sv
// ==============================
// Result selector
// Picks each test's answer from the bank that served it
// ==============================

`timescale 1ns/1ps
`include "filter_params.svh"

module result_select
#(
    parameter int N_BANKS = 1 << `FILTER_N_BANKS_RADIX
)
(
    input  logic                      clk,
    input  filter_pkg::bucket_idx_t   test_value_req,
    input  filter_pkg::bucket_idx_t   test_is_zero_req,
    input  filter_pkg::bucket_value_t value [N_BANKS],
    input  logic                      is_zero [N_BANKS],
    output filter_pkg::bucket_value_t test_value,
    output logic                      test_is_zero
);

    // Bank numbers of the two tests issued in one cycle
    typedef struct packed {
        filter_pkg::bank_idx_t value_bank;
        filter_pkg::bank_idx_t zero_bank;
    } bank_pair_t;

    filter_pkg::bucket_word_u value_w;
    filter_pkg::bucket_word_u zero_w;
    bank_pair_t               sel [0:2];

    always_comb
    begin
        value_w.idx = test_value_req;
        zero_w.idx = test_is_zero_req;
    end

    assign sel[0] = '{value_bank: value_w.split.bank, zero_bank: zero_w.split.bank};

    // Two stages to line up with the bank read latency
    always_ff @(posedge clk)
    begin
        sel[1] <= sel[0];
        sel[2] <= sel[1];
    end

    assign test_value = value[sel[2].value_bank];
    assign test_is_zero = is_zero[sel[2].zero_bank];

endmodule

//--- logic/banked_counting_filter.sv
// ==============================
// Banked counting filter
// Remove queue, bank router, counter banks and result selector
// ==============================

`timescale 1ns/1ps
`include "filter_params.svh"

module banked_counting_filter
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      insert_en,
    input  logic                      remove_en,
    input  filter_pkg::bucket_idx_t   insert,
    input  filter_pkg::bucket_idx_t   remove,
    input  filter_pkg::bucket_idx_t   test_value_req,
    input  filter_pkg::bucket_idx_t   test_is_zero_req,
    output filter_pkg::bucket_value_t test_value,
    output logic                      test_is_zero,
    output logic                      remove_not_full,
    output logic                      remove_almost_full
);

    localparam int N_BANKS = 1 << `FILTER_N_BANKS_RADIX;

    // Queue head and its grant
    filter_pkg::bucket_idx_t   remove_head;
    logic                      remove_valid;
    logic                      remove_deq;

    // Per-bank commands and results
    filter_pkg::bank_update_t  upd [N_BANKS];
    filter_pkg::bank_test_t    tests;
    filter_pkg::bucket_value_t bank_value [N_BANKS];
    logic                      bank_is_zero [N_BANKS];

    remove_queue remove_queue_i
    (
        .clk         (clk),
        .reset       (reset),
        .enq_en      (remove_en),
        .enq_data    (remove),
        .deq         (remove_deq),
        .head        (remove_head),
        .valid       (remove_valid),
        .not_full    (remove_not_full),
        .almost_full (remove_almost_full)
    );

    bank_router #(.N_BANKS(N_BANKS)) bank_router_i
    (
        .insert_en        (insert_en),
        .insert           (insert),
        .head             (remove_head),
        .test_value_req   (test_value_req),
        .test_is_zero_req (test_is_zero_req),
        .head_valid       (remove_valid),
        .deq              (remove_deq),
        .upd              (upd),
        .tests            (tests)
    );

    // One bank per value of the low index bits
    for (genvar b = 0; b < N_BANKS; b++)
    begin : bank
        counter_bank counter_bank_i
        (
            .clk     (clk),
            .reset   (reset),
            .upd     (upd[b]),
            .tests   (tests),
            .value   (bank_value[b]),
            .is_zero (bank_is_zero[b])
        );
    end

    result_select #(.N_BANKS(N_BANKS)) result_select_i
    (
        .clk              (clk),
        .test_value_req   (test_value_req),
        .test_is_zero_req (test_is_zero_req),
        .value            (bank_value),
        .is_zero          (bank_is_zero),
        .test_value       (test_value),
        .test_is_zero     (test_is_zero)
    );

endmodule

//--- verif/tb_banked_counting_filter.sv
// ==============================
// Banked counting filter testbench
// LFSR stimulus checked against a count and remove queue model
// ==============================

`timescale 1ns/1ps
`include "filter_params.svh"

module tb_banked_counting_filter;

    localparam int N_BANKS = 1 << `FILTER_N_BANKS_RADIX;
    localparam int N_BUCKETS = `FILTER_N_BUCKETS;
    localparam int PER_BANK = N_BUCKETS / N_BANKS;
    localparam int DEPTH = `FILTER_REMOVE_DEPTH;
    localparam int MAX_COUNT = 12;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      insert_en;
    logic                      remove_en;
    filter_pkg::bucket_idx_t   insert;
    filter_pkg::bucket_idx_t   remove;
    filter_pkg::bucket_idx_t   test_value_req;
    filter_pkg::bucket_idx_t   test_is_zero_req;
    filter_pkg::bucket_value_t test_value;
    logic                      test_is_zero;
    logic                      remove_not_full;
    logic                      remove_almost_full;

    // Model of every counter and of the pending removes in queue order
    int                        model_count [N_BUCKETS];
    filter_pkg::bucket_idx_t   model_queue [$];
    logic [31:0]               lfsr = 32'hf7a5_f305;
    // Expected results of the two tests in flight, index 1 being the older one
    logic                      pend_valid [2];
    int                        pend_value [2];
    logic                      pend_zero [2];
    int                        errors;
    int                        checks;

    always #5 clk = ~clk;

    banked_counting_filter banked_counting_filter_i
    (
        .clk                (clk),
        .reset              (reset),
        .insert_en          (insert_en),
        .remove_en          (remove_en),
        .insert             (insert),
        .remove             (remove),
        .test_value_req     (test_value_req),
        .test_is_zero_req   (test_is_zero_req),
        .test_value         (test_value),
        .test_is_zero       (test_is_zero),
        .remove_not_full    (remove_not_full),
        .remove_almost_full (remove_almost_full)
    );

    // ==============================
    // Random source and model helpers
    // ==============================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit handed out
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic int queued_removes(input int b);
        int n;
        n = 0;
        foreach (model_queue[i])
        begin
            if (model_queue[i] == b)
            begin
                n++;
            end
        end
        return n;
    endfunction

    // A bucket of the bank that may take an insert, or a remove when for_remove is set
    function automatic int pick_bucket(input int bank, input logic for_remove);
        int start;
        int b;
        start = random_bits(4);
        for (int j = 0; j < PER_BANK; j++)
        begin
            b = bank + N_BANKS * ((start + j) % PER_BANK);
            if (for_remove ? (model_count[b] - queued_removes(b) > 0)
                           : (model_count[b] < MAX_COUNT))
            begin
                return b;
            end
        end
        return -1;
    endfunction

    // ==============================
    // Checks and model update
    // ==============================

    // Queue flags reflect the occupancy at the start of this cycle
    task automatic check_outputs();
        logic exp_not_full;
        logic exp_almost;
        exp_not_full = (model_queue.size() != DEPTH);
        exp_almost = ((DEPTH - model_queue.size()) <= `FILTER_REMOVE_THRESHOLD);
        checks += 2;
        if (remove_not_full !== exp_not_full)
        begin
            errors++;
            $display("Mismatch at %0t: remove_not_full expected %0b, actual %0b",
                     $time, exp_not_full, remove_not_full);
        end
        if (remove_almost_full !== exp_almost)
        begin
            errors++;
            $display("Mismatch at %0t: remove_almost_full expected %0b, actual %0b",
                     $time, exp_almost, remove_almost_full);
        end
        if (pend_valid[1])
        begin
            checks += 2;
            if (test_value !== filter_pkg::bucket_value_t'(pend_value[1]))
            begin
                errors++;
                $display("Mismatch at %0t: test_value expected %0d, actual %0d",
                         $time, pend_value[1], test_value);
            end
            if (test_is_zero !== pend_zero[1])
            begin
                errors++;
                $display("Mismatch at %0t: test_is_zero expected %0b, actual %0b",
                         $time, pend_zero[1], test_is_zero);
            end
        end
    endtask

    // The head leaves unless an insert claims its bank, then this cycle's insert and remove land
    task automatic update_model(input logic ins_en, input int ins, input logic rem_en,
                                input int rem);
        int head;
        if (model_queue.size() > 0)
        begin
            head = model_queue[0];
            if (!(ins_en && ((ins % N_BANKS) == (head % N_BANKS))))
            begin
                model_count[head]--;
                void'(model_queue.pop_front());
            end
        end
        if (ins_en)
        begin
            model_count[ins]++;
        end
        if (rem_en)
        begin
            model_queue.push_back(filter_pkg::bucket_idx_t'(rem));
        end
    endtask

    // Drive one cycle of requests, then check and advance the model mid-cycle
    task automatic run_cycle(input logic ins_en, input int ins, input logic rem_en,
                             input int rem, input int tv, input int tz);
        @(posedge clk);
        insert_en <= ins_en;
        insert <= filter_pkg::bucket_idx_t'(ins);
        remove_en <= rem_en;
        remove <= filter_pkg::bucket_idx_t'(rem);
        test_value_req <= filter_pkg::bucket_idx_t'(tv);
        test_is_zero_req <= filter_pkg::bucket_idx_t'(tz);
        @(negedge clk);
        check_outputs();
        pend_valid[1] = pend_valid[0];
        pend_value[1] = pend_value[0];
        pend_zero[1] = pend_zero[0];
        // A test sees only the updates applied before its own cycle
        pend_valid[0] = 1'b1;
        pend_value[0] = model_count[tv];
        pend_zero[0] = (model_count[tz] == 0);
        update_model(ins_en, ins, rem_en, rem);
    endtask

    task automatic drain_queue();
        int cycles;
        cycles = 0;
        while ((model_queue.size() > 0) && (cycles < 100))
        begin
            run_cycle(1'b0, 0, 1'b0, 0, random_bits(6), random_bits(6));
            cycles++;
        end
        if (model_queue.size() > 0)
        begin
            errors++;
            $display("Remove queue did not drain within 100 cycles at %0t", $time);
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        int   ins;
        int   rem;
        int   last_ins;
        int   cycles;
        logic ins_en;
        logic rem_en;

        reset <= 1'b1;
        insert_en <= 1'b0;
        remove_en <= 1'b0;
        insert <= '0;
        remove <= '0;
        test_value_req <= '0;
        test_is_zero_req <= '0;
        foreach (model_count[i])
        begin
            model_count[i] = 0;
        end
        pend_valid[0] = 1'b0;
        pend_valid[1] = 1'b0;
        errors = 0;
        checks = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Every bucket reads back empty after reset
        for (int i = 0; i < N_BUCKETS; i++)
        begin
            run_cycle(1'b0, 0, 1'b0, 0, i, i);
        end

        // Inserts with tests in the same cycle or right after, hitting the bypass
        last_ins = 0;
        for (int i = 0; i < 200; i++)
        begin
            ins = random_bits(6);
            ins_en = (model_count[ins] < MAX_COUNT);
            run_cycle(ins_en, ins, 1'b0, 0, random_bits(1) ? last_ins : ins, last_ins);
            last_ins = ins;
        end

        // Mixed inserts and removes over all banks
        for (int i = 0; i < 400; i++)
        begin
            ins = random_bits(6);
            ins_en = random_bits(1) && (model_count[ins] < MAX_COUNT);
            rem = random_bits(6);
            rem_en = random_bits(1) && (model_queue.size() < DEPTH)
                     && (model_count[rem] - queued_removes(rem) > 0);
            run_cycle(ins_en, ins, rem_en, rem, random_bits(6), random_bits(6));
        end
        drain_queue();

        // Inserts keep bank 0 busy so its removes pile up until the queue is full
        cycles = 0;
        while ((model_queue.size() < DEPTH) && (cycles < 200))
        begin
            ins = pick_bucket(0, 1'b0);
            rem = pick_bucket(0, 1'b1);
            run_cycle(ins >= 0, (ins >= 0) ? ins : 0, rem >= 0, (rem >= 0) ? rem : 0,
                      random_bits(6), random_bits(6));
            cycles++;
        end
        if (model_queue.size() < DEPTH)
        begin
            errors++;
            $display("Remove queue never filled within 200 cycles at %0t", $time);
        end
        drain_queue();

        // Back-to-back updates to one bucket fold into the in-flight delta
        for (int i = 0; i < 150; i++)
        begin
            ins_en = random_bits(1) && (model_count[37] < MAX_COUNT);
            rem_en = random_bits(1) && (model_queue.size() < DEPTH)
                     && (model_count[37] - queued_removes(37) > 0);
            run_cycle(ins_en, 37, rem_en, 37, 37, 37);
        end
        drain_queue();
        run_cycle(1'b0, 0, 1'b0, 0, 37, 37);
        run_cycle(1'b0, 0, 1'b0, 0, 37, 37);
        run_cycle(1'b0, 0, 1'b0, 0, 37, 37);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+include
logic/filter_pkg.sv
logic/remove_queue.sv
logic/bank_router.sv
logic/counter_bank.sv
logic/result_select.sv
logic/banked_counting_filter.sv
verif/tb_banked_counting_filter.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert
TOP         = tb_banked_counting_filter
FILELIST    = sim.f
OBJ_DIR     = obj_dir
LOG         = sim.log
FAIL_MSG    = *** FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -F -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)
